/* all.f */
+incdir+.
audmix_pkg.sv
audmix_regs.sv
audmix_input_filter.sv
audmix_sum_stage.sv
audmix_crossfeed_stage.sv
audmix_att_clamp.sv
audmix_top.sv
audmix_checker.sv
tb_audmix.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the audio mixer testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Something failed"

verilator --binary --assert --timing --timescale 1ns/1ps \
	--top-module tb_audmix -f all.f -o tb_audmix
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_audmix > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

echo "simulation passed"
exit 0

/* tb_audmix.sv */
`timescale 1ns/1ps
`include "audmix_defs.svh"

module tb_audmix
	import audmix_pkg::*;
;

	localparam int CLK_NS = 8;
	localparam int RESET_CYC = 16;
	localparam int HOLD_CYC = 16;
	localparam int N_VEC = 48;
	localparam int N_APB = 40;
	localparam int WATCHDOG_NS = 2 * (RESET_CYC + N_VEC * HOLD_CYC + N_APB * 4) * CLK_NS;

	logic clk;
	logic resetd;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_AW-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	sample_t core_l;
	sample_t core_r;
	sample_t pcm_l;
	sample_t pcm_r;
	sample_t aud_l;
	sample_t aud_r;

	// settings as last written over apb
	mix_mode_e sh_mix;
	logic sh_signed;
	logic [`ATT_W-1:0] sh_att;

	logic [31:0] rng;
	string test_name;
	sample_t exp_l;
	sample_t exp_r;
	logic check_req = 1'b0;

	audmix_top uut (
		.clk       (clk),
		.resetd    (resetd),
		.i_psel    (psel),
		.i_penable (penable),
		.i_pwrite  (pwrite),
		.i_paddr   (paddr),
		.i_pwdata  (pwdata),
		.o_prdata  (prdata),
		.o_pready  (pready),
		.o_pslverr (pslverr),
		.i_core_l  (core_l),
		.i_core_r  (core_r),
		.i_pcm_l   (pcm_l),
		.i_pcm_r   (pcm_r),
		.o_aud_l   (aud_l),
		.o_aud_r   (aud_r)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int core_value(input sample_t v, input logic sgn);
		if (sgn)
			return int'($signed(v));
		// unsigned samples land at half scale
		return int'(v) / 2;
	endfunction

	function automatic int wrap17(input int x);
		logic [16:0] t;
		t = x[16:0];
		return int'($signed(t));
	endfunction

	function automatic int blend(input int sum, input int other, input mix_mode_e mode);
		case (mode)
			MIX_LOW: return wrap17(sum - (sum >>> 3) + (other >>> 2));
			MIX_MID: return wrap17(sum - (sum >>> 2) + (other >>> 1));
			MIX_FULL: return wrap17((sum >>> 1) + other);
			default: return sum;
		endcase
	endfunction

	function automatic sample_t scale_out(input int x, input logic [`ATT_W-1:0] att);
		int y;
		if (att[`ATT_W-1])
			return '0;
		y = x >>> att[`ATT_W-2:0];
		if (y > 32767)
			return 16'h7fff;
		if (y < -32768)
			return 16'h8000;
		return y[15:0];
	endfunction

	function automatic void ref_mix(input sample_t cl, input sample_t cr, input sample_t pl,
			input sample_t pr, input mix_mode_e mode, input logic sgn,
			input logic [`ATT_W-1:0] att, output sample_t out_l, output sample_t out_r);
		int sum_l;
		int sum_r;
		sum_l = core_value(cl, sgn) + int'($signed(pl));
		sum_r = core_value(cr, sgn) + int'($signed(pr));
		// other channel's half-scale sum feeds each blend
		out_l = scale_out(blend(sum_l, sum_r >>> 1, mode), att);
		out_r = scale_out(blend(sum_r, sum_l >>> 1, mode), att);
	endfunction

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (exp !== act) begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			$display("Something failed");
			$fatal(1, "sample mismatch");
		end
	endtask

	task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			$display("Something failed");
			$fatal(1, "register mismatch");
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("** Error: %s expected %b actual %b", name, exp, act);
			$display("Something failed");
			$fatal(1, "pslverr mismatch");
		end
	endtask

	task automatic check_ready(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("** Error: %s expected %b actual %b", name, exp, act);
			$display("Something failed");
			$fatal(1, "pready mismatch");
		end
	endtask

	initial begin
		forever begin
			wait (check_req);
			check_sample({test_name, " left"}, exp_l, aud_l);
			check_sample({test_name, " right"}, exp_r, aud_r);
			check_req = 1'b0;
		end
	end

	initial begin
		#WATCHDOG_NS;
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////
	// apb and stimulus tasks
	//////////////////////////////

	// setup cycle, access cycle, sampled just before release
	task automatic apb_access(input logic wr, input logic [`APB_AW-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		check_ready("pready in setup", 1'b0, pready);
		penable = 1'b1;
		@(negedge clk);
		check_ready("pready in access", 1'b1, pready);
		rdata = prdata;
		err = pslverr;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [31:0] data,
			output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [31:0] data,
			output logic err);
		apb_access(1'b0, addr, 32'h0, data, err);
	endtask

	task automatic set_ctrl(input mix_mode_e mode, input logic sgn);
		logic err;
		apb_write(REG_CTRL, {29'd0, sgn, mode}, err);
		check_err("ctrl write", 1'b0, err);
		sh_mix = mode;
		sh_signed = sgn;
	endtask

	task automatic set_vol(input logic [`ATT_W-1:0] att);
		logic err;
		apb_write(REG_VOL, {27'd0, att}, err);
		check_err("vol write", 1'b0, err);
		sh_att = att;
	endtask

	task automatic run_vector(input string name, input sample_t cl, input sample_t cr,
			input sample_t pl, input sample_t pr);
		@(negedge clk);
		core_l = cl;
		core_r = cr;
		pcm_l = pl;
		pcm_r = pr;
		ref_mix(cl, cr, pl, pr, sh_mix, sh_signed, sh_att, exp_l, exp_r);
		test_name = name;
		repeat (HOLD_CYC) @(negedge clk);
		check_req = 1'b1;
		wait (!check_req);
	endtask

	task automatic run_random(input string name);
		sample_t v[4];
		for (int i = 0; i < 4; i++) begin
			rng = xorshift32(rng);
			v[i] = rng[15:0];
		end
		run_vector(name, v[0], v[1], v[2], v[3]);
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		logic [31:0] rd;
		logic err;
		resetd = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		core_l = '0;
		core_r = '0;
		pcm_l = '0;
		pcm_r = '0;
		sh_mix = MIX_NONE;
		sh_signed = 1'b0;
		sh_att = '0;
		rng = 32'haf51;
		repeat (RESET_CYC) @(negedge clk);
		resetd = 1'b0;

		// register reset values and readback
		apb_read(REG_CTRL, rd, err);
		check_reg("ctrl after reset", 32'h0, rd);
		apb_read(REG_VOL, rd, err);
		check_reg("vol after reset", 32'h0, rd);
		apb_write(REG_CTRL, 32'hffff_fffe, err);
		apb_read(REG_CTRL, rd, err);
		check_reg("ctrl readback", 32'h6, rd);
		check_err("ctrl read", 1'b0, err);
		apb_write(REG_VOL, 32'hffff_ffea, err);
		apb_read(REG_VOL, rd, err);
		check_reg("vol readback", 32'h0a, rd);

		// unmapped offsets
		apb_write(4'h8, 32'hffff_ffff, err);
		check_err("unmapped write", 1'b1, err);
		apb_read(4'h2, rd, err);
		check_err("unmapped read", 1'b1, err);
		check_reg("unmapped read data", 32'h0, rd);
		apb_read(REG_CTRL, rd, err);
		check_reg("ctrl kept", 32'h6, rd);
		apb_read(REG_VOL, rd, err);
		check_reg("vol kept", 32'h0a, rd);

		// plain sum, unsigned then signed core
		set_vol(5'd0);
		set_ctrl(MIX_NONE, 1'b0);
		for (int i = 0; i < 8; i++)
			run_random("none unsigned");
		set_ctrl(MIX_NONE, 1'b1);
		for (int i = 0; i < 8; i++)
			run_random("none signed");

		// crossfeed modes
		set_ctrl(MIX_LOW, 1'b1);
		for (int i = 0; i < 4; i++)
			run_random("mix low");
		set_ctrl(MIX_MID, 1'b1);
		for (int i = 0; i < 4; i++)
			run_random("mix mid");
		set_ctrl(MIX_FULL, 1'b1);
		for (int i = 0; i < 4; i++)
			run_random("mix full");

		// attenuation and mute
		set_ctrl(MIX_NONE, 1'b1);
		for (int s = 1; s < 16; s++) begin
			set_vol(5'(s));
			run_random("attenuation");
		end
		set_vol(5'h13);
		run_random("mute");
		set_vol(5'd0);

		// same-sign full scale saturates
		run_vector("clamp", 16'h7f00, 16'h8100, 16'h7f00, 16'h8000);
		check_sample("clamp positive", 16'h7fff, aud_l);
		check_sample("clamp negative", 16'h8000, aud_r);
		run_vector("clamp swapped", 16'h8100, 16'h7f00, 16'h8000, 16'h7f00);
		check_sample("clamp negative swapped", 16'h8000, aud_l);
		check_sample("clamp positive swapped", 16'h7fff, aud_r);

		$display("Everything OK");
		$finish;
	end

endmodule

/* audmix_checker.sv */
`timescale 1ns/1ps
`include "audmix_defs.svh"

module audmix_checker
	import audmix_pkg::*;
(
	input logic              clk,
	input logic              resetd,
	input logic              i_psel,
	input logic              i_penable,
	input logic              i_pready,
	input logic              i_pslverr,
	input logic [`ATT_W-1:0] i_att,
	input sample_t           i_aud_l,
	input sample_t           i_aud_r
);

	logic mute;

	assign mute = i_att[`ATT_W-1];

	// no wait states, ready only in the access phase
	ready_in_access: assert property (@(posedge clk) i_pready == (i_psel && i_penable))
		else $error("pready does not follow the access phase");

	err_needs_ready: assert property (@(posedge clk) i_pslverr |-> i_pready)
		else $error("pslverr raised outside an access cycle");

	// shift and clamp registers sit behind the att input
	mute_gives_zero: assert property (@(posedge clk) disable iff (resetd)
		(mute && $past(mute, 1) && $past(mute, 2) && $past(mute, 3))
		|-> (i_aud_l == '0 && i_aud_r == '0))
		else $error("outputs not zero while muted");

endmodule

bind audmix_top audmix_checker u_checker (
	.clk       (clk),
	.resetd    (resetd),
	.i_psel    (i_psel),
	.i_penable (i_penable),
	.i_pready  (o_pready),
	.i_pslverr (o_pslverr),
	.i_att     (att),
	.i_aud_l   (o_aud_l),
	.i_aud_r   (o_aud_r)
);

/* audmix_top.sv */
`timescale 1ns/1ps
`include "audmix_defs.svh"

module audmix_top
	import audmix_pkg::*;
(
	input  logic               clk,
	input  logic               resetd,
	input  logic               i_psel,
	input  logic               i_penable,
	input  logic               i_pwrite,
	input  logic [`APB_AW-1:0] i_paddr,
	input  logic [31:0]        i_pwdata,
	output logic [31:0]        o_prdata,
	output logic               o_pready,
	output logic               o_pslverr,
	input  sample_t            i_core_l,
	input  sample_t            i_core_r,
	input  sample_t            i_pcm_l,
	input  sample_t            i_pcm_r,
	output sample_t            o_aud_l,
	output sample_t            o_aud_r
);

	mix_mode_e         mix;
	logic              is_signed;
	logic [`ATT_W-1:0] att;

	sample_t core_l;
	sample_t core_r;
	acc_t    sum_l;
	acc_t    sum_r;
	sample_t pre_l;
	sample_t pre_r;
	acc_t    xf_l;
	acc_t    xf_r;

	//////////////////////////////
	// settings
	//////////////////////////////

	audmix_regs u_regs (
		.clk       (clk),
		.resetd    (resetd),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.o_mix     (mix),
		.o_signed  (is_signed),
		.o_att     (att)
	);

	//////////////////////////////
	// left channel
	//////////////////////////////

	audmix_input_filter u_filt_l (
		.clk      (clk),
		.resetd   (resetd),
		.i_sample (i_core_l),
		.o_sample (core_l)
	);

	audmix_sum_stage u_sum_l (
		.clk      (clk),
		.resetd   (resetd),
		.i_sample (core_l),
		.i_pcm    (i_pcm_l),
		.i_signed (is_signed),
		.o_sum    (sum_l),
		.o_pre    (pre_l)
	);

	// right half scale feeds the left blend
	audmix_crossfeed_stage u_xf_l (
		.clk         (clk),
		.resetd      (resetd),
		.i_sum       (sum_l),
		.i_other_pre (pre_r),
		.i_mix       (mix),
		.o_mix       (xf_l)
	);

	audmix_att_clamp u_att_l (
		.clk      (clk),
		.resetd   (resetd),
		.i_mix    (xf_l),
		.i_att    (att),
		.o_sample (o_aud_l)
	);

	//////////////////////////////
	// right channel
	//////////////////////////////

	audmix_input_filter u_filt_r (
		.clk      (clk),
		.resetd   (resetd),
		.i_sample (i_core_r),
		.o_sample (core_r)
	);

	audmix_sum_stage u_sum_r (
		.clk      (clk),
		.resetd   (resetd),
		.i_sample (core_r),
		.i_pcm    (i_pcm_r),
		.i_signed (is_signed),
		.o_sum    (sum_r),
		.o_pre    (pre_r)
	);

	audmix_crossfeed_stage u_xf_r (
		.clk         (clk),
		.resetd      (resetd),
		.i_sum       (sum_r),
		.i_other_pre (pre_l),
		.i_mix       (mix),
		.o_mix       (xf_r)
	);

	audmix_att_clamp u_att_r (
		.clk      (clk),
		.resetd   (resetd),
		.i_mix    (xf_r),
		.i_att    (att),
		.o_sample (o_aud_r)
	);

endmodule

/* audmix_att_clamp.sv */
`timescale 1ns/1ps
`include "audmix_defs.svh"

module audmix_att_clamp
	import audmix_pkg::*;
(
	input  logic              clk,
	input  logic              resetd,
	input  acc_t              i_mix,
	input  logic [`ATT_W-1:0] i_att,
	output sample_t           o_sample
);

	acc_t shifted;
	logic ovf;

	// volume step of 6 dB per shift
	always_ff @(posedge clk) begin
		if (resetd) begin
			shifted <= '0;
		end else if (i_att[`ATT_W-1]) begin
			shifted <= '0;
		end else begin
			shifted <= i_mix >>> i_att[`ATT_W-2:0];
		end
	end

	// guard bit and sign disagree, value is out of 16 bit range
	assign ovf = shifted[`ACC_W-1] ^ shifted[`ACC_W-2];

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_sample <= '0;
		end else if (ovf) begin
			o_sample <= {shifted[`ACC_W-1], {(`AUD_W-1){~shifted[`ACC_W-1]}}};
		end else begin
			o_sample <= shifted[`AUD_W-1:0];
		end
	end

endmodule

/* audmix_crossfeed_stage.sv */
`timescale 1ns/1ps
`include "audmix_defs.svh"

module audmix_crossfeed_stage
	import audmix_pkg::*;
(
	input  logic      clk,
	input  logic      resetd,
	input  acc_t      i_sum,
	input  sample_t   i_other_pre,
	input  mix_mode_e i_mix,
	output acc_t      o_mix
);

	acc_t other;
	acc_t mix_next;

	// other channel is already half scale
	assign other = {i_other_pre[`AUD_W-1], i_other_pre};

	//////////////////////////////
	// blend, wraps at 17 bits
	//////////////////////////////

	always_comb begin
		case (i_mix)
			MIX_LOW: begin
				mix_next = i_sum - (i_sum >>> 3) + (other >>> 2);
			end
			MIX_MID: begin
				mix_next = i_sum - (i_sum >>> 2) + (other >>> 1);
			end
			MIX_FULL: begin
				// plain mono
				mix_next = (i_sum >>> 1) + other;
			end
			default: begin
				mix_next = i_sum;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_mix <= '0;
		end else begin
			o_mix <= mix_next;
		end
	end

endmodule

/* audmix_sum_stage.sv */
`timescale 1ns/1ps
`include "audmix_defs.svh"

module audmix_sum_stage
	import audmix_pkg::*;
(
	input  logic    clk,
	input  logic    resetd,
	input  sample_t i_sample,
	input  sample_t i_pcm,
	input  logic    i_signed,
	output acc_t    o_sum,
	output sample_t o_pre
);

	acc_t conv;
	acc_t pcm_ext;
	acc_t sum_next;

	// host pcm is always two's complement
	assign pcm_ext = {i_pcm[`AUD_W-1], i_pcm};
	assign sum_next = conv + pcm_ext;

	// unsigned core audio is halved, so it sits at half scale
	always_ff @(posedge clk) begin
		if (resetd) begin
			conv <= '0;
		end else if (i_signed) begin
			conv <= {i_sample[`AUD_W-1], i_sample};
		end else begin
			conv <= {2'b00, i_sample[`AUD_W-1:1]};
		end
	end

	// half scale copy goes to the other channel with the sum
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_sum <= '0;
			o_pre <= '0;
		end else begin
			o_sum <= sum_next;
			o_pre <= sum_next[`ACC_W-1:1];
		end
	end

endmodule

/* audmix_input_filter.sv */
`timescale 1ns/1ps
`include "audmix_defs.svh"

module audmix_input_filter
	import audmix_pkg::*;
(
	input  logic    clk,
	input  logic    resetd,
	input  sample_t i_sample,
	output sample_t o_sample
);

	// core audio may come from another clock, so it can be
	// caught halfway through an update
	sample_t dly1;
	sample_t dly2;
	sample_t dly3;

	always_ff @(posedge clk) begin
		if (resetd) begin
			dly1 <= '0;
			dly2 <= '0;
			dly3 <= '0;
		end else begin
			dly1 <= i_sample;
			dly2 <= dly1;
			dly3 <= dly2;
		end
	end

	// hold the last value seen twice in a row
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_sample <= '0;
		end else if (dly2 == dly3) begin
			o_sample <= dly2;
		end
	end

endmodule

/* audmix_regs.sv */
`timescale 1ns/1ps
`include "audmix_defs.svh"

module audmix_regs
	import audmix_pkg::*;
(
	input  logic              clk,
	input  logic              resetd,
	input  logic              i_psel,
	input  logic              i_penable,
	input  logic              i_pwrite,
	input  logic [`APB_AW-1:0] i_paddr,
	input  logic [31:0]       i_pwdata,
	output logic [31:0]       o_prdata,
	output logic              o_pready,
	output logic              o_pslverr,
	output mix_mode_e         o_mix,
	output logic              o_signed,
	output logic [`ATT_W-1:0] o_att
);

	logic access;
	logic hit_ctrl;
	logic hit_vol;

	// access phase of a transfer, never any wait states
	assign access = i_psel & i_penable;

	always_comb begin
		hit_ctrl = 1'b0;
		hit_vol = 1'b0;
		case (i_paddr)
			REG_CTRL: hit_ctrl = 1'b1;
			REG_VOL: hit_vol = 1'b1;
			default: ;
		endcase
	end

	assign o_pready = access;
	assign o_pslverr = access & ~hit_ctrl & ~hit_vol;

	//////////////////////////////
	// read path
	//////////////////////////////

	always_comb begin
		o_prdata = '0;
		if (access & ~i_pwrite) begin
			if (hit_ctrl) begin
				o_prdata[2:0] = {o_signed, o_mix};
			end
			if (hit_vol) begin
				o_prdata[`ATT_W-1:0] = o_att;
			end
		end
	end

	//////////////////////////////
	// write path
	//////////////////////////////

	// takes effect on the edge that closes the access cycle
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_mix <= MIX_NONE;
			o_signed <= 1'b0;
			o_att <= '0;
		end else if (access & i_pwrite) begin
			if (hit_ctrl) begin
				o_mix <= mix_mode_e'(i_pwdata[1:0]);
				o_signed <= i_pwdata[2];
			end
			if (hit_vol) begin
				o_att <= i_pwdata[`ATT_W-1:0];
			end
		end
	end

endmodule

/* audmix_pkg.sv */
`include "audmix_defs.svh"

package audmix_pkg;

	// sample as carried on the ports, sign handled by each stage
	typedef logic [`AUD_W-1:0] sample_t;

	// value passed between the stages
	typedef logic signed [`ACC_W-1:0] acc_t;

	// crossfeed between left and right
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_LOW  = 2'd1,
		MIX_MID  = 2'd2,
		MIX_FULL = 2'd3
	} mix_mode_e;

	// register offsets on the apb port
	typedef enum logic [`APB_AW-1:0] {
		REG_CTRL = `REG_CTRL_OFS,
		REG_VOL  = `REG_VOL_OFS
	} reg_addr_e;

endpackage

/* audmix_defs.svh */
`ifndef AUDMIX_DEFS_SVH
`define AUDMIX_DEFS_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

// one audio sample on the ports
`define AUD_W 16

// signed accumulator, one guard bit above a sample
`define ACC_W (`AUD_W + 1)

// attenuation field, top bit is mute, rest is the shift
`define ATT_W 5

//////////////////////////////
// apb register map
//////////////////////////////

`define APB_AW 4

`define REG_CTRL_OFS 0
`define REG_VOL_OFS  4

`endif
